// File: bench/axi_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 slave memory, 64 KB, one burst at a time per direction. Ready and
// valid stalls are random. Burst rule violations pulse rule_err_o.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  axis2axi_pkg::axi_ax_t   aw_i,
   input  wire                     awvalid_i,
   output logic                    awready_o,
   input  axis2axi_pkg::axi_w_t    w_i,
   input  wire                     wvalid_i,
   output logic                    wready_o,
   output logic                    bvalid_o,
   input  wire                     bready_i,
   input  axis2axi_pkg::axi_ax_t   ar_i,
   input  wire                     arvalid_i,
   output logic                    arready_o,
   output axis2axi_pkg::axi_r_t    r_o,
   output logic                    rvalid_o,
   input  wire                     rready_i,
   output logic                    rule_err_o
);

   localparam int WORDS = 16384;

   axis2axi_pkg::data_t   mem [WORDS];
   axis2axi_pkg::axi_ax_t aw_log [64];
   axis2axi_pkg::axi_ax_t ar_log [64];
   int                    aw_count;
   int                    ar_count;

   bit wr_active;
   bit b_pending;
   int wr_word;
   int wr_len;
   int wr_beat;
   bit rd_active;
   int rd_word;
   int rd_len;
   int rd_beat;
   bit err;
   bit r_taken;

   function automatic bit burst_ok(input string ch, input axis2axi_pkg::axi_ax_t ax);
      bit ok;
      ok = 1'b1;
      if (ax.len > 8'd3) begin
         $display("%0t: %s burst at %h is longer than 4 beats", $time, ch, ax.addr);
         ok = 1'b0;
      end
      if (int'(ax.addr[11:0]) + 4 * (int'(ax.len) + 1) > 4096) begin
         $display("%0t: %s burst at %h crosses a 4 KB boundary", $time, ch, ax.addr);
         ok = 1'b0;
      end
      return ok;
   endfunction

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'h6b8b4567 ^ (32'(i) * 32'h01000193);
      end
      aw_count   = 0;
      ar_count   = 0;
      awready_o  = 1'b0;
      wready_o   = 1'b0;
      bvalid_o   = 1'b0;
      arready_o  = 1'b0;
      rvalid_o   = 1'b0;
      r_o        = '0;
      rule_err_o = 1'b0;
   end

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_active  = 1'b0;
         b_pending  = 1'b0;
         rd_active  = 1'b0;
         awready_o  = 1'b0;
         wready_o   = 1'b0;
         bvalid_o   = 1'b0;
         arready_o  = 1'b0;
         rvalid_o   = 1'b0;
         rule_err_o = 1'b0;
      end else begin
         err     = 1'b0;
         r_taken = 1'b0;
         if (awvalid_i && awready_o) begin
            if (aw_count < 64) aw_log[aw_count] = aw_i;
            aw_count++;
            if (!burst_ok("AW", aw_i)) err = 1'b1;
            wr_active = 1'b1;
            wr_word   = int'(aw_i.addr) / 4;
            wr_len    = int'(aw_i.len);
            wr_beat   = 0;
         end
         if (wvalid_i && wready_o) begin
            mem[(wr_word + wr_beat) % WORDS] = w_i.data;
            if (w_i.last != (wr_beat == wr_len)) begin
               $display("%0t: W last flag disagrees with AW len at beat %0d", $time, wr_beat);
               err = 1'b1;
            end
            if (wr_beat == wr_len) begin
               wr_active = 1'b0;
               b_pending = 1'b1;
            end
            wr_beat++;
         end
         if (bvalid_o && bready_i) b_pending = 1'b0;
         if (arvalid_i && arready_o) begin
            if (ar_count < 64) ar_log[ar_count] = ar_i;
            ar_count++;
            if (!burst_ok("AR", ar_i)) err = 1'b1;
            rd_active = 1'b1;
            rd_word   = int'(ar_i.addr) / 4;
            rd_len    = int'(ar_i.len);
            rd_beat   = 0;
         end
         if (rvalid_o && rready_i) begin
            r_taken = 1'b1;
            if (rd_beat == rd_len) rd_active = 1'b0;
            rd_beat++;
         end

         #5;
         awready_o  = !wr_active && !b_pending && ($urandom % 4 != 0);
         wready_o   = wr_active && ($urandom % 4 != 0);
         bvalid_o   = b_pending && (bvalid_o || ($urandom % 2 == 0));
         arready_o  = !rd_active && ($urandom % 4 != 0);
         rule_err_o = err;
         // R beat holds until taken
         if (!rvalid_o || r_taken) begin
            rvalid_o   = rd_active && ($urandom % 4 != 0);
            r_o.data   = mem[(rd_word + rd_beat) % WORDS];
            r_o.last   = (rd_beat == rd_len);
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/axis2axi_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the stream to AXI bridge. Reads only cover addresses that
// were written earlier in the run.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_defines.svh"

module axis2axi_tb;

   localparam int TOTAL_WORDS    = 2 * (37 + 10 + 0 + 24);
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 200;

   logic                  clk_i;
   logic                  rst_n_i;
   axis2axi_pkg::cfg_t    cfg_in_i;
   logic                  cfg_in_valid_i;
   logic                  cfg_in_ready_o;
   axis2axi_pkg::data_t   axis_in_data_i;
   logic                  axis_in_valid_i;
   logic                  axis_in_ready_o;
   axis2axi_pkg::cfg_t    cfg_out_i;
   logic                  cfg_out_valid_i;
   logic                  cfg_out_ready_o;
   axis2axi_pkg::data_t   axis_out_data_o;
   logic                  axis_out_valid_o;
   logic                  axis_out_ready_i;

   axis2axi_pkg::axi_ax_t axi_aw;
   logic                  axi_awvalid;
   logic                  axi_awready;
   axis2axi_pkg::axi_w_t  axi_w;
   logic                  axi_wvalid;
   logic                  axi_wready;
   logic                  axi_bvalid;
   logic                  axi_bready;
   axis2axi_pkg::axi_ax_t axi_ar;
   logic                  axi_arvalid;
   logic                  axi_arready;
   axis2axi_pkg::axi_r_t  axi_r;
   logic                  axi_rvalid;
   logic                  axi_rready;
   logic                  rule_err;

   axis2axi_pkg::data_t   shadow [16384];
   int                    errors;
   int                    rule_errors;
   int                    timeouts;
   int                    cycles;
   int                    bus_busy;
   int                    busy_before;

   axis2axi dut0 (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .cfg_in_i (cfg_in_i), .cfg_in_valid_i (cfg_in_valid_i),
      .cfg_in_ready_o (cfg_in_ready_o), .axis_in_data_i (axis_in_data_i),
      .axis_in_valid_i (axis_in_valid_i), .axis_in_ready_o (axis_in_ready_o),
      .cfg_out_i (cfg_out_i), .cfg_out_valid_i (cfg_out_valid_i),
      .cfg_out_ready_o (cfg_out_ready_o), .axis_out_data_o (axis_out_data_o),
      .axis_out_valid_o (axis_out_valid_o), .axis_out_ready_i (axis_out_ready_i),
      .axi_aw_o (axi_aw), .axi_awvalid_o (axi_awvalid), .axi_awready_i (axi_awready),
      .axi_w_o (axi_w), .axi_wvalid_o (axi_wvalid), .axi_wready_i (axi_wready),
      .axi_bvalid_i (axi_bvalid), .axi_bready_o (axi_bready),
      .axi_ar_o (axi_ar), .axi_arvalid_o (axi_arvalid), .axi_arready_i (axi_arready),
      .axi_r_i (axi_r), .axi_rvalid_i (axi_rvalid), .axi_rready_o (axi_rready)
   );

   axi_mem_model mem0 (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .aw_i (axi_aw), .awvalid_i (axi_awvalid), .awready_o (axi_awready),
      .w_i (axi_w), .wvalid_i (axi_wvalid), .wready_o (axi_wready),
      .bvalid_o (axi_bvalid), .bready_i (axi_bready),
      .ar_i (axi_ar), .arvalid_i (axi_arvalid), .arready_o (axi_arready),
      .r_o (axi_r), .rvalid_o (axi_rvalid), .rready_i (axi_rready),
      .rule_err_o (rule_err)
   );

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   // Smallest of burst limit, words left and words to the 4 KB edge
   function automatic int expected_bursts(input int addr, input int length,
                                          output int addrs[64], output int beats[64]);
      int n;
      int a;
      int remain;
      int b;
      int to_edge;
      n      = 0;
      a      = addr;
      remain = length;
      while (remain > 0 && n < 64) begin
         b = 1 << `AXIS2AXI_BURST_W;
         if (remain < b) b = remain;
         to_edge = (4096 - (a % 4096)) / 4;
         if (to_edge < b) b = to_edge;
         addrs[n] = a;
         beats[n] = b;
         n++;
         a      += 4 * b;
         remain -= b;
      end
      return n;
   endfunction

   function automatic int word_index(input axis2axi_pkg::addr_t addr, input int k);
      return (int'(addr) / 4 + k) % 16384;
   endfunction

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      if (got !== expected) begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
      end
   endtask

   task automatic check_bursts(input string name, input bit is_wr, input int first,
                               input int addr, input int length);
      int addrs[64];
      int beats[64];
      int n;
      int logged;
      int i;
      axis2axi_pkg::axi_ax_t ax;
      n      = expected_bursts(addr, length, addrs, beats);
      logged = is_wr ? mem0.aw_count - first : mem0.ar_count - first;
      check({name, " burst count"}, 32'(logged), 32'(n));
      for (i = 0; i < n && i < logged; i++) begin
         ax = is_wr ? mem0.aw_log[first + i] : mem0.ar_log[first + i];
         check({name, " addr"}, 32'(ax.addr), 32'(addrs[i]));
         check({name, " len"}, 32'(ax.len), 32'(beats[i] - 1));
      end
   endtask

   task automatic write_words(input axis2axi_pkg::addr_t addr, input int n, input bit gaps);
      int i;
      axis2axi_pkg::data_t word;
      cfg_in_i.addr   = addr;
      cfg_in_i.length = axis2axi_pkg::words_t'(n);
      cfg_in_valid_i  = 1'b1;
      @(posedge clk_i);
      while (!cfg_in_ready_o) @(posedge clk_i);
      #5;
      cfg_in_valid_i = 1'b0;
      i    = 0;
      word = $urandom;
      while (i < n) begin
         // A raised valid stays up until the word is taken
         if (axis_in_valid_i || !gaps || ($urandom % 3 != 0)) begin
            axis_in_valid_i = 1'b1;
            axis_in_data_i  = word;
         end
         @(posedge clk_i);
         if (axis_in_valid_i && axis_in_ready_o) begin
            shadow[word_index(addr, i)] = word;
            i++;
            word = $urandom;
            #5;
            axis_in_valid_i = 1'b0;
         end else begin
            #5;
         end
      end
      @(posedge clk_i);
      while (!cfg_in_ready_o) @(posedge clk_i);
      check("axis_in_ready_o after write", 32'(axis_in_ready_o), 32'd0);
      #5;
   endtask

   task automatic read_words(input axis2axi_pkg::addr_t addr, input int n, input bit stall);
      int i;
      cfg_out_i.addr   = addr;
      cfg_out_i.length = axis2axi_pkg::words_t'(n);
      cfg_out_valid_i  = 1'b1;
      @(posedge clk_i);
      while (!cfg_out_ready_o) @(posedge clk_i);
      #5;
      cfg_out_valid_i = 1'b0;
      i = 0;
      while (i < n) begin
         axis_out_ready_i = !stall || ($urandom % 2 == 0);
         @(posedge clk_i);
         if (axis_out_valid_o && axis_out_ready_i) begin
            check("axis_out_data_o", axis_out_data_o, shadow[word_index(addr, i)]);
            i++;
         end
         #5;
      end
      axis_out_ready_i = 1'b0;
      @(posedge clk_i);
      while (!cfg_out_ready_o) @(posedge clk_i);
      check("axis_out_valid_o after read", 32'(axis_out_valid_o), 32'd0);
      #5;
   endtask

   task automatic run_test(input axis2axi_pkg::addr_t addr, input int n, input bit stall);
      int aw_first;
      int ar_first;
      aw_first = mem0.aw_count;
      write_words(addr, n, stall);
      check_bursts("AW", 1'b1, aw_first, int'(addr), n);
      ar_first = mem0.ar_count;
      read_words(addr, n, stall);
      check_bursts("AR", 1'b0, ar_first, int'(addr), n);
   endtask

   task automatic report_and_finish();
      $display("Errors: %0d data, %0d bus rule, %0d timeout", errors, rule_errors, timeouts);
      if (errors == 0 && rule_errors == 0 && timeouts == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   always @(posedge clk_i) begin
      if (axi_awvalid || axi_wvalid || axi_bvalid || axi_arvalid || axi_rvalid) begin
         bus_busy <= bus_busy + 1;
      end
      if (rule_err) begin
         rule_errors <= rule_errors + 1;
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         timeouts = 1;
         report_and_finish();
      end
   end

   initial begin
      void'($urandom(32'h5c22c1a8));
      rst_n_i          = 1'b0;
      cfg_in_i         = '0;
      cfg_in_valid_i   = 1'b0;
      axis_in_data_i   = '0;
      axis_in_valid_i  = 1'b0;
      cfg_out_i        = '0;
      cfg_out_valid_i  = 1'b0;
      axis_out_ready_i = 1'b1;
      repeat (2) @(posedge clk_i);
      #5;
      rst_n_i = 1'b1;

      // Idle outputs after reset
      @(posedge clk_i);
      check("cfg_in_ready_o", 32'(cfg_in_ready_o), 32'd1);
      check("cfg_out_ready_o", 32'(cfg_out_ready_o), 32'd1);
      check("axi_awvalid_o", 32'(axi_awvalid), 32'd0);
      check("axi_wvalid_o", 32'(axi_wvalid), 32'd0);
      check("axi_arvalid_o", 32'(axi_arvalid), 32'd0);
      check("axis_out_valid_o", 32'(axis_out_valid_o), 32'd0);
      check("axi_bready_o", 32'(axi_bready), 32'd0);
      check("axi_rready_o", 32'(axi_rready), 32'd0);
      #5;

      run_test(16'h0100, 37, 1'b0);
      run_test(16'h0ff8, 10, 1'b0);

      busy_before = bus_busy;
      run_test(16'h0200, 0, 1'b0);
      @(posedge clk_i);
      check("AXI valid cycles", 32'(bus_busy), 32'(busy_before));
      check("cfg_in_ready_o", 32'(cfg_in_ready_o), 32'd1);
      check("cfg_out_ready_o", 32'(cfg_out_ready_o), 32'd1);
      #5;

      run_test(16'h2000, 24, 1'b1);

      @(posedge clk_i);
      report_and_finish();
   end

endmodule

`default_nettype wire

// File: logic/axis2axi.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream to AXI4 bridge. ID, lock, cache, prot and QoS are fixed by the
// bus wrapper. Word aligned addresses only.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module axis2axi (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   // Write request and input stream
   input  axis2axi_pkg::cfg_t      cfg_in_i,
   input  wire                     cfg_in_valid_i,
   output logic                    cfg_in_ready_o,
   input  axis2axi_pkg::data_t     axis_in_data_i,
   input  wire                     axis_in_valid_i,
   output logic                    axis_in_ready_o,

   // Read request and output stream
   input  axis2axi_pkg::cfg_t      cfg_out_i,
   input  wire                     cfg_out_valid_i,
   output logic                    cfg_out_ready_o,
   output axis2axi_pkg::data_t     axis_out_data_o,
   output logic                    axis_out_valid_o,
   input  wire                     axis_out_ready_i,

   // AXI4 master
   output axis2axi_pkg::axi_ax_t   axi_aw_o,
   output logic                    axi_awvalid_o,
   input  wire                     axi_awready_i,
   output axis2axi_pkg::axi_w_t    axi_w_o,
   output logic                    axi_wvalid_o,
   input  wire                     axi_wready_i,
   input  wire                     axi_bvalid_i,
   output logic                    axi_bready_o,
   output axis2axi_pkg::axi_ax_t   axi_ar_o,
   output logic                    axi_arvalid_o,
   input  wire                     axi_arready_i,
   input  axis2axi_pkg::axi_r_t    axi_r_i,
   input  wire                     axi_rvalid_i,
   output logic                    axi_rready_o
);

   logic                 fifo_full;
   logic                 fifo_push;
   logic                 fifo_pop;
   logic                 axis_accept;
   axis2axi_pkg::data_t  fifo_data;
   axis2axi_pkg::beats_t fifo_level;

   // Stream words enter only when there is room and the request wants them
   assign axis_in_ready_o = !fifo_full && axis_accept;
   assign fifo_push       = axis_in_ready_o && axis_in_valid_i;

   axis_burst_fifo buf0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (fifo_push),
      .data_i  (axis_in_data_i),
      .full_o  (fifo_full),
      .pop_i   (fifo_pop),
      .data_o  (fifo_data),
      .level_o (fifo_level)
   );

   axis2axi_in wr0 (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg_in_i),
      .cfg_valid_i   (cfg_in_valid_i),
      .cfg_ready_o   (cfg_in_ready_o),
      .fifo_level_i  (fifo_level),
      .fifo_push_i   (fifo_push),
      .fifo_pop_o    (fifo_pop),
      .fifo_data_i   (fifo_data),
      .axi_aw_o      (axi_aw_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_w_o       (axi_w_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o),
      .axis_accept_o (axis_accept)
   );

   axis2axi_out rd0 (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg_out_i),
      .cfg_valid_i   (cfg_out_valid_i),
      .cfg_ready_o   (cfg_out_ready_o),
      .axi_ar_o      (axi_ar_o),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_arready_i (axi_arready_i),
      .axi_r_i       (axi_r_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rready_o  (axi_rready_o),
      .axis_data_o   (axis_out_data_o),
      .axis_valid_o  (axis_out_valid_o),
      .axis_ready_i  (axis_out_ready_i)
   );

endmodule

`default_nettype wire

// File: logic/axis2axi_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths of the stream to AXI bridge. Only 4 byte words are supported.
// Buffer depth is always two bursts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef AXIS2AXI_DEFINES_SVH
`define AXIS2AXI_DEFINES_SVH

// Byte address and word widths
`define AXIS2AXI_ADDR_W 16
`define AXIS2AXI_DATA_W 32

// AXI4 burst length field
`define AXIS2AXI_LEN_W 8

// Burst limit is 2**BURST_W words
`define AXIS2AXI_BURST_W 2
`define AXIS2AXI_BUF_W (`AXIS2AXI_BURST_W + 1)

`endif

// File: logic/axis2axi_in.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write engine. A burst starts only once all its words sit in the buffer.
// One burst in flight on AW/W/B at a time; B errors are ignored.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module axis2axi_in (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   // Write request
   input  axis2axi_pkg::cfg_t      cfg_i,
   input  wire                     cfg_valid_i,
   output logic                    cfg_ready_o,

   // Burst buffer
   input  axis2axi_pkg::beats_t    fifo_level_i,
   input  wire                     fifo_push_i,
   output logic                    fifo_pop_o,
   input  axis2axi_pkg::data_t     fifo_data_i,

   // AXI write address
   output axis2axi_pkg::axi_ax_t   axi_aw_o,
   output logic                    axi_awvalid_o,
   input  wire                     axi_awready_i,

   // AXI write data
   output axis2axi_pkg::axi_w_t    axi_w_o,
   output logic                    axi_wvalid_o,
   input  wire                     axi_wready_i,

   // AXI write response
   input  wire                     axi_bvalid_i,
   output logic                    axi_bready_o,

   // Stream words still wanted by the request
   output logic                    axis_accept_o
);

   axis2axi_pkg::in_state_e state;
   axis2axi_pkg::addr_t     cur_addr;
   axis2axi_pkg::words_t    remain;
   axis2axi_pkg::words_t    unbuf;
   axis2axi_pkg::beats_t    beats;
   axis2axi_pkg::beats_t    beats_q;
   axis2axi_pkg::beats_t    beat_cnt;
   logic                    w_last;

   assign beats  = axis2axi_pkg::burst_beats(cur_addr, remain);
   assign w_last = (beat_cnt == beats_q - 1'b1);

   assign cfg_ready_o   = (state == axis2axi_pkg::IN_WAIT_START);
   assign axis_accept_o = (unbuf != '0);

   assign axi_aw_o.addr = cur_addr;
   assign axi_aw_o.len  = axis2axi_pkg::axlen_t'(beats_q) - 8'd1;
   assign axi_awvalid_o = (state == axis2axi_pkg::IN_ADDRESS);

   assign axi_w_o.data = fifo_data_i;
   assign axi_w_o.last = w_last;
   assign axi_wvalid_o = (state == axis2axi_pkg::IN_DATA);
   assign fifo_pop_o   = axi_wvalid_o & axi_wready_i;

   assign axi_bready_o = (state == axis2axi_pkg::IN_RESPONSE);

   // Words of the request not yet pushed into the buffer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         unbuf <= '0;
      end else if (cfg_ready_o && cfg_valid_i) begin
         unbuf <= cfg_i.length;
      end else if (fifo_push_i) begin
         unbuf <= unbuf - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= axis2axi_pkg::IN_WAIT_START;
         cur_addr <= '0;
         remain   <= '0;
         beats_q  <= '0;
         beat_cnt <= '0;
      end else begin
         case (state)
            axis2axi_pkg::IN_WAIT_START: begin
               if (cfg_valid_i) begin
                  cur_addr <= cfg_i.addr;
                  remain   <= cfg_i.length;
                  if (cfg_i.length != '0) begin
                     state <= axis2axi_pkg::IN_FILL;
                  end
               end
            end
            axis2axi_pkg::IN_FILL: begin
               // Wait for the whole burst in the buffer
               if (fifo_level_i >= beats) begin
                  beats_q <= beats;
                  remain  <= remain - axis2axi_pkg::words_t'(beats);
                  state   <= axis2axi_pkg::IN_ADDRESS;
               end
            end
            axis2axi_pkg::IN_ADDRESS: begin
               if (axi_awready_i) begin
                  beat_cnt <= '0;
                  state    <= axis2axi_pkg::IN_DATA;
               end
            end
            axis2axi_pkg::IN_DATA: begin
               if (fifo_pop_o) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (w_last) begin
                     cur_addr <= cur_addr + axis2axi_pkg::addr_t'({beats_q, 2'b00});
                     state    <= axis2axi_pkg::IN_RESPONSE;
                  end
               end
            end
            axis2axi_pkg::IN_RESPONSE: begin
               if (axi_bvalid_i) begin
                  if (remain == '0) begin
                     state <= axis2axi_pkg::IN_WAIT_START;
                  end else begin
                     state <= axis2axi_pkg::IN_FILL;
                  end
               end
            end
            default: state <= axis2axi_pkg::IN_WAIT_START;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/axis2axi_out.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read engine. INCR bursts of 4 byte beats only; error responses ignored.
// A request is taken only while cfg_ready_o is high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module axis2axi_out (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   // Read request
   input  axis2axi_pkg::cfg_t      cfg_i,
   input  wire                     cfg_valid_i,
   output logic                    cfg_ready_o,

   // AXI read address
   output axis2axi_pkg::axi_ax_t   axi_ar_o,
   output logic                    axi_arvalid_o,
   input  wire                     axi_arready_i,

   // AXI read data
   input  axis2axi_pkg::axi_r_t    axi_r_i,
   input  wire                     axi_rvalid_i,
   output logic                    axi_rready_o,

   // Output stream
   output axis2axi_pkg::data_t     axis_data_o,
   output logic                    axis_valid_o,
   input  wire                     axis_ready_i
);

   axis2axi_pkg::out_state_e state;
   axis2axi_pkg::addr_t      cur_addr;
   axis2axi_pkg::words_t     remain;
   axis2axi_pkg::axlen_t     len_q;
   axis2axi_pkg::beats_t     beats;
   logic                     in_burst;
   logic                     r_fire;

   assign beats    = axis2axi_pkg::burst_beats(cur_addr, remain);
   assign in_burst = (state == axis2axi_pkg::OUT_END_LOCAL);
   assign r_fire   = axi_rvalid_i & axi_rready_o;

   assign cfg_ready_o = (state == axis2axi_pkg::OUT_WAIT_START);

   assign axi_ar_o.addr = cur_addr;
   assign axi_ar_o.len  = len_q;
   assign axi_arvalid_o = (state == axis2axi_pkg::OUT_TRANSFER);

   // Read data goes straight through to the stream
   assign axis_data_o  = axi_r_i.data;
   assign axis_valid_o = in_burst & axi_rvalid_i;
   assign axi_rready_o = in_burst & axis_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= axis2axi_pkg::OUT_WAIT_START;
         cur_addr <= '0;
         remain   <= '0;
         len_q    <= '0;
      end else begin
         case (state)
            axis2axi_pkg::OUT_WAIT_START: begin
               if (cfg_valid_i) begin
                  cur_addr <= cfg_i.addr;
                  remain   <= cfg_i.length;
                  // Zero length leaves the engine idle
                  if (cfg_i.length != '0) begin
                     state <= axis2axi_pkg::OUT_BEGIN_LOCAL;
                  end
               end
            end
            axis2axi_pkg::OUT_BEGIN_LOCAL: begin
               len_q  <= axis2axi_pkg::axlen_t'(beats) - 8'd1;
               remain <= remain - axis2axi_pkg::words_t'(beats);
               state  <= axis2axi_pkg::OUT_TRANSFER;
            end
            axis2axi_pkg::OUT_TRANSFER: begin
               if (axi_arready_i) begin
                  state <= axis2axi_pkg::OUT_END_LOCAL;
               end
            end
            axis2axi_pkg::OUT_END_LOCAL: begin
               if (r_fire && axi_r_i.last) begin
                  // Step past the burst just read
                  cur_addr <= cur_addr + axis2axi_pkg::addr_t'({len_q + 8'd1, 2'b00});
                  if (remain == '0) begin
                     state <= axis2axi_pkg::OUT_WAIT_START;
                  end else begin
                     state <= axis2axi_pkg::OUT_BEGIN_LOCAL;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/axis2axi_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types and the burst rule shared by both engines. Addresses must be word
// aligned; bursts never cross a 4 KB boundary.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "axis2axi_defines.svh"

package axis2axi_pkg;

   typedef logic [`AXIS2AXI_ADDR_W-1:0] addr_t;
   typedef logic [`AXIS2AXI_ADDR_W-1:0] words_t;
   typedef logic [`AXIS2AXI_DATA_W-1:0] data_t;
   typedef logic [`AXIS2AXI_LEN_W-1:0]  axlen_t;
   typedef logic [`AXIS2AXI_BURST_W:0]  beats_t;

   typedef struct packed {
      addr_t  addr;
      words_t length;
   } cfg_t;

   typedef struct packed {
      addr_t  addr;
      axlen_t len;
   } axi_ax_t;

   typedef struct packed {
      data_t data;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      data_t data;
      logic  last;
   } axi_r_t;

   typedef enum logic [1:0] {
      OUT_WAIT_START,
      OUT_BEGIN_LOCAL,
      OUT_TRANSFER,
      OUT_END_LOCAL
   } out_state_e;

   typedef enum logic [2:0] {
      IN_WAIT_START,
      IN_FILL,
      IN_ADDRESS,
      IN_DATA,
      IN_RESPONSE
   } in_state_e;

   // Smallest of burst limit, remaining words and words to the 4 KB boundary
   function automatic beats_t burst_beats(addr_t addr, words_t remain);
      logic [12:0] to_boundary;
      beats_t      beats;
      to_boundary = (13'h1000 - {1'b0, addr[11:0]}) >> 2;
      beats = beats_t'(1 << `AXIS2AXI_BURST_W);
      if (remain < words_t'(beats)) begin
         beats = beats_t'(remain);
      end
      if (to_boundary < 13'(beats)) begin
         beats = beats_t'(to_boundary);
      end
      return beats;
   endfunction

endpackage

`default_nettype wire

// File: logic/axis_burst_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-burst word buffer. The caller never pushes when full or pops when
// empty. level_o saturates at one burst.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_defines.svh"

module axis_burst_fifo (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  wire                     push_i,
   input  axis2axi_pkg::data_t     data_i,
   output logic                    full_o,
   input  wire                     pop_i,
   output axis2axi_pkg::data_t     data_o,
   output axis2axi_pkg::beats_t    level_o
);

   axis2axi_pkg::data_t            mem [2**`AXIS2AXI_BUF_W];
   logic [`AXIS2AXI_BUF_W-1:0]     wr_ptr;
   logic [`AXIS2AXI_BUF_W-1:0]     rd_ptr;
   logic [`AXIS2AXI_BUF_W:0]       count;

   // Top bit of count set only at full depth
   assign full_o = count[`AXIS2AXI_BUF_W];
   assign data_o = mem[rd_ptr];

   // Any count of a burst or more reads as one burst
   assign level_o = (count[`AXIS2AXI_BUF_W:`AXIS2AXI_BURST_W] != '0) ?
                    axis2axi_pkg::beats_t'(1 << `AXIS2AXI_BURST_W) :
                    axis2axi_pkg::beats_t'(count);

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push_i && !pop_i) begin
            count <= count + 1'b1;
         end else if (pop_i && !push_i) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
   -f sources.f \
   --top-module axis2axi_tb \
   -o axis2axi_sim

./obj_dir/axis2axi_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
   echo "Run passed"
   exit 0
else
   echo "Run did not pass, see sim.log"
   exit 1
fi

// File: sources.f
+incdir+logic
logic/axis2axi_pkg.sv
logic/axis_burst_fifo.sv
logic/axis2axi_in.sv
logic/axis2axi_out.sv
logic/axis2axi.sv
bench/axi_mem_model.sv
bench/axis2axi_tb.sv
